//--- Bender.yml
package:
  name: as2650

sources:
  - files:
      - as2650_pkg.sv
      - as2650_regfile.sv
      - as2650_alu.sv
      - as2650_sequencer.sv
      - as2650.sv
  - target: test
    files:
      - tb_as2650_assertions.sv
      - tb_as2650.sv

//--- as2650.sv
`timescale 1ns/1ps
`default_nettype none

module as2650 #(
	parameter as2650_pkg::addr_t reset_vector = '0
) (
	input logic clk,
	input logic reset,
	output as2650_pkg::addr_t adr,
	input as2650_pkg::byte_t dbus_in,
	output as2650_pkg::byte_t dbus_out,
	output logic oeb,
	output logic rw,
	output logic opreq,
	output logic wrp
);
	import as2650_pkg::*;

	logic rs;
	reg_sel_t rd_sel;
	byte_t rd_data;
	byte_t r0_data;
	logic reg_wr_en;
	reg_sel_t reg_wr_sel;
	byte_t reg_wr_data;
	alu_op_t alu_op;
	byte_t alu_a;
	byte_t alu_b;
	logic with_carry;
	logic carry_in;
	logic logical_compare;
	byte_t alu_result;
	cc_t alu_cc;
	logic alu_carry;
	logic alu_idc;
	logic alu_ovf;

	as2650_sequencer #(
		.reset_vector(reset_vector)
	) u_sequencer (
		.clk(clk),
		.reset(reset),
		.adr(adr),
		.dbus_in(dbus_in),
		.dbus_out(dbus_out),
		.opreq(opreq),
		.rw(rw),
		.wrp(wrp),
		.oeb(oeb),
		.rs(rs),
		.rd_sel(rd_sel),
		.rd_data(rd_data),
		.r0_data(r0_data),
		.reg_wr_en(reg_wr_en),
		.reg_wr_sel(reg_wr_sel),
		.reg_wr_data(reg_wr_data),
		.alu_op(alu_op),
		.alu_a(alu_a),
		.alu_b(alu_b),
		.with_carry(with_carry),
		.carry_in(carry_in),
		.logical_compare(logical_compare),
		.alu_result(alu_result),
		.alu_cc(alu_cc),
		.alu_carry(alu_carry),
		.alu_idc(alu_idc),
		.alu_ovf(alu_ovf)
	);

	as2650_regfile u_regfile (
		.clk(clk),
		.reset(reset),
		.rs(rs),
		.rd_sel(rd_sel),
		.rd_data(rd_data),
		.r0_data(r0_data),
		.wr_en(reg_wr_en),
		.wr_sel(reg_wr_sel),
		.wr_data(reg_wr_data)
	);

	as2650_alu u_alu (
		.op(alu_op),
		.a(alu_a),
		.b(alu_b),
		.with_carry(with_carry),
		.carry_in(carry_in),
		.logical_compare(logical_compare),
		.result(alu_result),
		.cc(alu_cc),
		.carry_out(alu_carry),
		.idc_out(alu_idc),
		.ovf_out(alu_ovf)
	);

endmodule

`default_nettype wire

//--- as2650_alu.sv
`timescale 1ns/1ps
`default_nettype none

module as2650_alu (
	input as2650_pkg::alu_op_t op,
	input as2650_pkg::byte_t a,
	input as2650_pkg::byte_t b,
	input logic with_carry,
	input logic carry_in,
	input logic logical_compare,
	output as2650_pkg::byte_t result,
	output as2650_pkg::cc_t cc,
	output logic carry_out,
	output logic idc_out,
	output logic ovf_out
);
	import as2650_pkg::*;

	byte_t b_eff; // Inverted for subtract
	logic cin;
	logic [8:0] sum;
	logic [4:0] nib_sum; // Low nibble only, for IDC
	logic a_gt_b;
	logic a_lt_b;

	assign b_eff = (op == op_sub) ? ~b : b;

	always_comb begin
		if (op == op_sub) begin
			cin = with_carry ? carry_in : 1'b1; // Carry set means no borrow
		end else begin
			cin = with_carry & carry_in;
		end
	end

	assign sum = {1'b0, a} + {1'b0, b_eff} + {8'b0, cin};
	assign nib_sum = {1'b0, a[3:0]} + {1'b0, b_eff[3:0]} + {4'b0, cin};

	assign carry_out = sum[8];
	assign idc_out = nib_sum[4];
	assign ovf_out = (a[7] == b_eff[7]) && (sum[7] != a[7]);

	always_comb begin
		case (op)
			op_eor: result = a ^ b;
			op_and: result = a & b;
			op_ior: result = a | b;
			op_add, op_sub: result = sum[7:0];
			op_lod, op_str, op_com: result = b; // Operand passes straight through
		endcase
	end

	assign a_gt_b = logical_compare ? (a > b) : ($signed(a) > $signed(b));
	assign a_lt_b = logical_compare ? (a < b) : ($signed(a) < $signed(b));

	always_comb begin
		if (op == op_com) begin
			cc = a_gt_b ? 2'b01 : (a_lt_b ? 2'b10 : 2'b00);
		end else if (result[7]) begin
			cc = 2'b10;
		end else if (result != '0) begin
			cc = 2'b01;
		end else begin
			cc = 2'b00;
		end
	end

endmodule

`default_nettype wire

//--- as2650_pkg.sv
`default_nettype none

package as2650_pkg;

	typedef logic [7:0] byte_t; // Bus and register data
	typedef logic [12:0] addr_t; // 8K address space
	typedef logic [1:0] reg_sel_t; // 0 picks r0
	typedef logic [1:0] cc_t; // 00 zero, 01 positive, 10 negative
	typedef logic [2:0] alu_op_t; // Instruction bits 7:5
	typedef logic [1:0] mode_t; // Instruction bits 3:2

	// Operation field
	localparam alu_op_t op_lod = 3'd0;
	localparam alu_op_t op_eor = 3'd1;
	localparam alu_op_t op_and = 3'd2;
	localparam alu_op_t op_ior = 3'd3;
	localparam alu_op_t op_add = 3'd4;
	localparam alu_op_t op_sub = 3'd5;
	localparam alu_op_t op_str = 3'd6;
	localparam alu_op_t op_com = 3'd7;

	// Addressing modes, relative (2) is not decoded
	localparam mode_t mode_zero = 2'd0;
	localparam mode_t mode_imm = 2'd1;
	localparam mode_t mode_abs = 2'd3;

	localparam byte_t opc_halt = 8'h40; // Sits in the andz r0 slot
	localparam byte_t opc_nop = 8'hC0; // Sits in the strz r0 slot
	localparam byte_t opc_ppsl = 8'h77;
	localparam byte_t opc_cpsl = 8'h75;
	localparam byte_t opc_bcta_base = 8'h1C; // Low two bits hold the condition
	localparam byte_t opc_bcfa_base = 8'h9C;

	// PSL bit positions
	localparam int psl_cc_lo = 6; // CC occupies bits 7:6
	localparam int psl_idc = 5;
	localparam int psl_rs = 4;
	localparam int psl_wc = 3;
	localparam int psl_ovf = 2;
	localparam int psl_com = 1;
	localparam int psl_c = 0;

	typedef enum logic [3:0] {
		st_fetch,
		st_decode,
		st_arg,
		st_abs_lo,
		st_operand,
		st_execute,
		st_write,
		st_write_end,
		st_branch_lo,
		st_halted
	} seq_state_t;

endpackage

`default_nettype wire

//--- as2650_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module as2650_regfile (
	input logic clk,
	input logic reset,
	input logic rs,
	input as2650_pkg::reg_sel_t rd_sel,
	output as2650_pkg::byte_t rd_data,
	output as2650_pkg::byte_t r0_data,
	input logic wr_en,
	input as2650_pkg::reg_sel_t wr_sel,
	input as2650_pkg::byte_t wr_data
);
	import as2650_pkg::*;

	byte_t r0; // Shared by both banks
	byte_t banks [2][3]; // r1 to r3, one row per bank
	logic [1:0] rd_idx;
	logic [1:0] wr_idx;

	assign rd_idx = rd_sel - 2'd1;
	assign wr_idx = wr_sel - 2'd1;
	assign r0_data = r0;

	always_comb begin
		if (rd_sel == 2'd0) begin
			rd_data = r0;
		end else begin
			rd_data = banks[rs][rd_idx];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			r0 <= '0;
			for (int b = 0; b < 2; b++) begin
				for (int i = 0; i < 3; i++) begin
					banks[b][i] <= '0;
				end
			end
		end else if (wr_en) begin
			if (wr_sel == 2'd0) begin
				r0 <= wr_data;
			end else begin
				banks[rs][wr_idx] <= wr_data; // RS picks the bank
			end
		end
	end

endmodule

`default_nettype wire

//--- as2650_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module as2650_sequencer #(
	parameter as2650_pkg::addr_t reset_vector = '0
) (
	input logic clk,
	input logic reset,
	output as2650_pkg::addr_t adr,
	input as2650_pkg::byte_t dbus_in,
	output as2650_pkg::byte_t dbus_out,
	output logic opreq,
	output logic rw,
	output logic wrp,
	output logic oeb,
	output logic rs,
	output as2650_pkg::reg_sel_t rd_sel,
	input as2650_pkg::byte_t rd_data,
	input as2650_pkg::byte_t r0_data,
	output logic reg_wr_en,
	output as2650_pkg::reg_sel_t reg_wr_sel,
	output as2650_pkg::byte_t reg_wr_data,
	output as2650_pkg::alu_op_t alu_op,
	output as2650_pkg::byte_t alu_a,
	output as2650_pkg::byte_t alu_b,
	output logic with_carry,
	output logic carry_in,
	output logic logical_compare,
	input as2650_pkg::byte_t alu_result,
	input as2650_pkg::cc_t alu_cc,
	input logic alu_carry,
	input logic alu_idc,
	input logic alu_ovf
);
	import as2650_pkg::*;

	seq_state_t state;
	addr_t pc;
	byte_t ir; // Opcode of the running instruction
	byte_t hold; // Immediate or memory operand
	byte_t addr_hi; // First byte of an absolute address
	byte_t psl;
	alu_op_t ir_op;
	logic zero_mode;
	logic writes_reg;
	logic updates_cc;
	logic cc_match;
	logic branch_taken;

	function automatic logic is_alu(byte_t code);
		return !code[4] && code != opc_halt && code != opc_nop &&
			(code[3:2] == mode_zero || code[3:2] == mode_imm || code[3:2] == mode_abs);
	endfunction

	function automatic logic is_branch(byte_t code);
		return code[7:2] == opc_bcta_base[7:2] || code[7:2] == opc_bcfa_base[7:2];
	endfunction

	assign ir_op = ir[7:5];
	assign zero_mode = (ir[3:2] == mode_zero);
	assign writes_reg = (ir_op != op_com) && (zero_mode || ir_op != op_str); // No stri
	assign updates_cc = writes_reg || ir_op == op_com;

	// Bit 7 of the opcode tells bcfa from bcta
	assign cc_match = (psl[psl_cc_lo +: 2] == ir[1:0]);
	assign branch_taken = ir[7] ? !cc_match : (cc_match || ir[1:0] == 2'b11);

	assign oeb = ~rw;
	assign rs = psl[psl_rs];
	assign rd_sel = ir[1:0];
	assign alu_op = ir_op;
	assign with_carry = psl[psl_wc];
	assign carry_in = psl[psl_c];
	assign logical_compare = psl[psl_com];

	// Zero mode works on r0 and rN, strz moves r0 out to rN
	assign alu_a = zero_mode ? r0_data : rd_data;
	assign alu_b = !zero_mode ? hold : (ir_op == op_str ? r0_data : rd_data);
	assign reg_wr_en = (state == st_execute) && !ir[4] && writes_reg;
	assign reg_wr_sel = (zero_mode && ir_op != op_str) ? 2'd0 : ir[1:0];
	assign reg_wr_data = alu_result;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_fetch;
			pc <= reset_vector;
			adr <= reset_vector;
			ir <= opc_nop;
			psl <= '0;
			opreq <= 1'b0;
			rw <= 1'b0;
			wrp <= 1'b0;
		end else begin
			case (state)
				st_fetch: begin
					opreq <= 1'b1;
					rw <= 1'b0;
					adr <= pc;
					pc <= pc + 1'b1;
					state <= st_decode;
				end
				st_decode: begin
					ir <= dbus_in;
					if (dbus_in == opc_halt) begin
						opreq <= 1'b0;
						state <= st_halted;
					end else if (is_alu(dbus_in) && dbus_in[3:2] == mode_zero) begin
						opreq <= 1'b0; // Both operands already in registers
						state <= st_execute;
					end else if (is_alu(dbus_in) || is_branch(dbus_in) ||
						dbus_in == opc_ppsl || dbus_in == opc_cpsl) begin
						adr <= pc;
						pc <= pc + 1'b1;
						state <= st_arg;
					end else begin
						opreq <= 1'b0; // Unknown opcodes behave as nop
						state <= st_fetch;
					end
				end
				st_arg: begin
					if (ir[3:2] == mode_abs) begin
						addr_hi <= dbus_in;
						adr <= pc;
						pc <= pc + 1'b1;
						state <= is_branch(ir) ? st_branch_lo : st_abs_lo;
					end else begin
						hold <= dbus_in;
						opreq <= 1'b0;
						state <= st_execute;
					end
				end
				st_abs_lo: begin
					adr <= {addr_hi[4:0], dbus_in}; // Indirect and index bits ignored
					if (ir_op == op_str) begin
						rw <= 1'b1;
						dbus_out <= rd_data;
						state <= st_write;
					end else begin
						state <= st_operand;
					end
				end
				st_operand: begin
					hold <= dbus_in;
					opreq <= 1'b0;
					state <= st_execute;
				end
				st_execute: begin
					if (ir == opc_ppsl) begin
						psl <= psl | hold;
					end else if (ir == opc_cpsl) begin
						psl <= psl & ~hold;
					end else if (updates_cc) begin
						psl[psl_cc_lo +: 2] <= alu_cc;
						if (ir_op == op_add || ir_op == op_sub) begin
							psl[psl_c] <= alu_carry;
							psl[psl_idc] <= alu_idc;
							psl[psl_ovf] <= alu_ovf;
						end
					end
					state <= st_fetch;
				end
				st_write: begin
					wrp <= 1'b1;
					state <= st_write_end;
				end
				st_write_end: begin
					wrp <= 1'b0;
					opreq <= 1'b0;
					rw <= 1'b0;
					state <= st_fetch;
				end
				st_branch_lo: begin
					if (branch_taken) begin
						pc <= {addr_hi[4:0], dbus_in};
					end
					opreq <= 1'b0;
					state <= st_fetch;
				end
				st_halted: begin
					state <= st_halted; // Only reset gets out of here
				end
				default: begin
					state <= st_fetch;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- compile.f
as2650_pkg.sv
as2650_regfile.sv
as2650_alu.sv
as2650_sequencer.sv
as2650.sv
tb_as2650_assertions.sv
tb_as2650.sv

//--- tb_as2650.sv
`timescale 1ns/1ps
`default_nettype none

module tb_as2650;
	import as2650_pkg::*;

	localparam addr_t reset_vector = 13'h0040;
	localparam addr_t result_base = 13'h1000;
	localparam int watchdog_ns = 2 * 6 * 64 * 10 * 4; // Tests x instructions x cycles x period

	logic clk = 1'b0;
	logic reset = 1'b1;
	addr_t adr;
	byte_t dbus_in;
	byte_t dbus_out;
	logic oeb;
	logic rw;
	logic opreq;
	logic wrp;

	byte_t mem [8192];
	addr_t wp; // Program write pointer
	addr_t rp; // Next result slot
	addr_t exp_addr [$];
	byte_t exp_val [$];
	logic [31:0] seed = 32'h9136_25f1;
	int errors = 0;
	int checks = 0;
	int tests_done = 0;
	int test_start_errors = 0;
	int write_count = 0;
	logic watch_halt = 1'b0;
	logic halt_next_fetch = 1'b0;
	addr_t halt_addr = '0;
	logic compare_req = 1'b0;

	as2650 #(
		.reset_vector(reset_vector)
	) u_dut (
		.clk(clk),
		.reset(reset),
		.adr(adr),
		.dbus_in(dbus_in),
		.dbus_out(dbus_out),
		.oeb(oeb),
		.rw(rw),
		.opreq(opreq),
		.wrp(wrp)
	);

	always #2 clk = ~clk;

	assign dbus_in = mem[adr]; // Reads answer in the same cycle

	always @(posedge clk) begin
		if (wrp) begin
			mem[adr] = dbus_out;
			write_count = write_count + 1;
		end
		if (watch_halt && opreq && !rw && adr == halt_addr + 13'd1) begin
			halt_next_fetch = 1'b1;
		end
	end

	function automatic byte_t next_byte();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed[23:16];
	endfunction

	// Carry out in bit 8, result in bits 7:0
	function automatic logic [8:0] alu_ref(alu_op_t op, byte_t a, byte_t b, logic c, logic wc);
		logic [8:0] r;
		case (op)
			op_eor: r = {1'b0, a ^ b};
			op_and: r = {1'b0, a & b};
			op_ior: r = {1'b0, a | b};
			op_add: r = {1'b0, a} + {1'b0, b} + (wc & c);
			op_sub: begin
				r = {1'b0, a} - {1'b0, b} - (wc & !c); // Clear C means borrow
				r[8] = !r[8];
			end
			default: r = {1'b0, b};
		endcase
		return r;
	endfunction

	function automatic cc_t cmp_ref(byte_t a, byte_t b, logic unsigned_cmp);
		int sa;
		int sb;
		sa = unsigned_cmp ? int'(a) : int'($signed(a));
		sb = unsigned_cmp ? int'(b) : int'($signed(b));
		if (sa > sb) begin
			return 2'b01;
		end else if (sa < sb) begin
			return 2'b10;
		end
		return 2'b00;
	endfunction

	function automatic logic taken_ref(logic on_false, cc_t cc, logic [1:0] cond);
		if (on_false) begin
			return cc != cond;
		end
		return cc == cond || cond == 2'b11;
	endfunction

	task automatic check_value(string name, logic [15:0] actual, logic [15:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic emit(byte_t b);
		mem[wp] = b;
		wp = wp + 13'd1;
	endtask

	task automatic emit_abs(byte_t opc, addr_t a);
		emit(opc);
		emit({3'b000, a[12:8]});
		emit(a[7:0]);
	endtask

	// Stores rN into the next result slot
	task automatic store_expect(reg_sel_t r, byte_t value);
		emit_abs(8'hCC | r, rp);
		exp_addr.push_back(rp);
		exp_val.push_back(value);
		rp = rp + 13'd1;
	endtask

	task automatic clear_memory();
		for (int i = 0; i < 8192; i++) begin
			mem[i] = i[7:0] ^ {3'b000, i[12:8]} ^ 8'hA5;
		end
		wp = reset_vector;
		rp = result_base;
		exp_addr.delete();
		exp_val.delete();
	endtask

	task automatic run_program();
		int quiet;
		@(posedge clk);
		#1;
		reset = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		check_value("opreq", opreq, 1'b0); // Also the value seen on the first edge after reset
		check_value("rw", rw, 1'b0);
		check_value("wrp", wrp, 1'b0);
		check_value("oeb", oeb, 1'b1);
		reset = 1'b0;
		@(posedge clk);
		#1;
		check_value("opreq", opreq, 1'b1);
		check_value("adr", adr, reset_vector);
		quiet = 0;
		while (quiet < 16) begin // Halted core leaves the bus idle
			@(posedge clk);
			#1;
			quiet = opreq ? 0 : quiet + 1;
		end
	endtask

	always begin
		wait (compare_req);
		foreach (exp_addr[i]) begin
			check_value($sformatf("mem[%h]", exp_addr[i]), mem[exp_addr[i]], exp_val[i]);
		end
		compare_req = 1'b0;
	end

	task automatic end_test(string name);
		compare_req = 1'b1;
		wait (!compare_req);
		$display("%-12s %s", name, (errors == test_start_errors) ? "passed" : "failed");
		test_start_errors = errors;
		tests_done++;
	endtask

	task automatic test_reset();
		clear_memory();
		emit(opc_halt);
		run_program();
		end_test("reset");
	endtask

	task automatic test_immediate();
		byte_t a;
		byte_t b;
		alu_op_t op;
		reg_sel_t r;
		logic [8:0] y;
		clear_memory();
		for (int i = 0; i < 20; i++) begin
			a = next_byte();
			b = next_byte();
			op = alu_op_t'(next_byte() % 5 + 1); // eor to sub
			r = reg_sel_t'(next_byte());
			y = alu_ref(op, a, b, 1'b0, 1'b0);
			emit(8'h04 | r);
			emit(a);
			emit({op, 3'b001, r});
			emit(b);
			store_expect(r, y[7:0]);
		end
		emit(opc_halt);
		run_program();
		end_test("immediate");
	endtask

	task automatic test_banks();
		byte_t v [6];
		byte_t x;
		clear_memory();
		foreach (v[i]) begin
			v[i] = next_byte();
		end
		x = next_byte();
		for (int i = 0; i < 3; i++) begin
			emit(byte_t'(8'h05 + i)); // lodi r1 to r3, bank 0
			emit(v[i]);
		end
		emit(opc_ppsl);
		emit(8'h10);
		for (int i = 0; i < 3; i++) begin
			emit(byte_t'(8'h05 + i));
			emit(v[i + 3]);
		end
		for (int i = 0; i < 3; i++) begin
			store_expect(reg_sel_t'(i + 1), v[i + 3]);
		end
		emit(opc_cpsl);
		emit(8'h10);
		for (int i = 0; i < 3; i++) begin
			emit(byte_t'(8'h01 + i)); // lodz rN
			store_expect(2'd0, v[i]);
		end
		emit(8'h04);
		emit(x);
		emit(opc_ppsl);
		emit(8'h10);
		emit(8'hC1); // strz r1 lands in bank 1
		emit(opc_cpsl);
		emit(8'h10);
		store_expect(2'd1, v[0]);
		store_expect(2'd0, x);
		emit(opc_ppsl);
		emit(8'h10);
		store_expect(2'd1, x);
		emit(opc_halt);
		run_program();
		end_test("banks");
	endtask

	task automatic test_carry();
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] y;
		clear_memory();
		emit(opc_ppsl);
		emit(8'h08); // WC on
		for (int i = 0; i < 4; i++) begin
			a = {next_byte(), next_byte()};
			b = {next_byte(), next_byte()};
			for (int s = 0; s < 2; s++) begin
				y = s ? a - b : a + b;
				emit(s ? opc_ppsl : opc_cpsl); // C set means no borrow into sub
				emit(8'h01);
				emit(8'h05);
				emit(a[7:0]);
				emit(s ? 8'hA5 : 8'h85);
				emit(b[7:0]);
				emit(8'h06);
				emit(a[15:8]);
				emit(s ? 8'hA6 : 8'h86); // High byte takes the carry
				emit(b[15:8]);
				store_expect(2'd1, y[7:0]);
				store_expect(2'd2, y[15:8]);
			end
		end
		emit(opc_halt);
		run_program();
		end_test("carry");
	endtask

	task automatic test_branches();
		byte_t a;
		byte_t b;
		logic [1:0] cond;
		logic on_false;
		addr_t taken_at;
		clear_memory();
		for (int m = 0; m < 2; m++) begin
			emit(m == 1 ? opc_ppsl : opc_cpsl); // COM set gives unsigned compare
			emit(8'h02);
			for (int i = 0; i < 4; i++) begin
				a = next_byte();
				b = (i == 0) ? a : next_byte();
				cond = 2'(next_byte());
				on_false = i[0];
				emit(8'h05);
				emit(a);
				emit(8'hE5); // comi r1
				emit(b);
				taken_at = wp + 13'd8;
				emit_abs(on_false ? (opc_bcfa_base | cond) : (opc_bcta_base | cond), taken_at);
				emit(8'h06);
				emit(8'h0F);
				emit_abs(opc_bcta_base | 8'h03, taken_at + 13'd2); // Skip the taken path
				emit(8'h06);
				emit(8'hF0);
				store_expect(2'd2,
					taken_ref(on_false, cmp_ref(a, b, m == 1), cond) ? 8'hF0 : 8'h0F);
			end
		end
		emit(opc_halt);
		run_program();
		end_test("branches");
	endtask

	task automatic test_halt();
		byte_t x;
		clear_memory();
		x = next_byte();
		emit(8'h05);
		emit(x);
		store_expect(2'd1, x);
		halt_addr = wp;
		emit(opc_halt);
		emit_abs(8'hCD, rp); // Must never run
		exp_addr.push_back(rp);
		exp_val.push_back(mem[rp]);
		write_count = 0;
		halt_next_fetch = 1'b0;
		watch_halt = 1'b1;
		run_program();
		watch_halt = 1'b0;
		check_value("write_count", write_count, 1);
		check_value("halt_next_fetch", halt_next_fetch, 1'b0);
		end_test("halt");
	endtask

	initial begin
		test_reset();
		test_immediate();
		test_banks();
		test_carry();
		test_branches();
		test_halt();
		$display("%0d tests, %0d checks, %0d errors, %0d assertion failures", tests_done,
			checks, errors, u_dut.u_bus_assertions.violations);
		if (errors == 0 && u_dut.u_bus_assertions.violations == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin
		#(watchdog_ns);
		$display("The run hung: the core did not go idle within %0d ns", watchdog_ns);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb_as2650_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module as2650_bus_assertions (
	input logic clk,
	input logic reset,
	input logic opreq,
	input logic rw,
	input logic wrp,
	input logic oeb
);
	int unsigned violations = 0; // Failure count

	wrp_in_write: assert property (@(posedge clk) disable iff (reset) wrp |-> opreq && rw)
		else begin
			violations++;
			$error("wrp high without opreq and rw");
		end

	wrp_single: assert property (@(posedge clk) disable iff (reset) wrp |=> !wrp)
		else begin
			violations++;
			$error("wrp high for two cycles in a row");
		end

	oeb_inverse: assert property (@(posedge clk) oeb == !rw)
		else begin
			violations++;
			$error("oeb is not the inverse of rw");
		end

endmodule

bind as2650 as2650_bus_assertions u_bus_assertions (
	.clk(clk),
	.reset(reset),
	.opreq(opreq),
	.rw(rw),
	.wrp(wrp),
	.oeb(oeb)
);

`default_nettype wire
